// File: hdl/mmu_exc_pkg.sv
package mmu_exc_pkg;

    typedef logic [6:0] exc_code_t;

    // Ecode values with the ADEM esubcode in the top bit
    localparam exc_code_t exc_none = 7'h00;
    localparam exc_code_t exc_pil  = 7'h01;
    localparam exc_code_t exc_pis  = 7'h02;
    localparam exc_code_t exc_pif  = 7'h03;
    localparam exc_code_t exc_pme  = 7'h04;
    localparam exc_code_t exc_ppi  = 7'h07;
    localparam exc_code_t exc_adef = 7'h08;
    localparam exc_code_t exc_adem = 7'h48;
    localparam exc_code_t exc_tlbr = 7'h3f;

    typedef enum logic [1:0] {
        mem_load  = 2'd0,
        mem_store = 2'd1,
        mem_fetch = 2'd2
    } mem_type_t;

    typedef struct packed {
        logic        en;
        logic [31:0] vaddr;
        mem_type_t   mem_type;
        logic [1:0]  plv;
    } lookup_req_t;

    typedef struct packed {
        logic        found;
        logic        v;
        logic        d;
        logic [1:0]  plv;
        logic [19:0] ppn;
    } tlb_hit_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        dmw_hit;
        exc_code_t   exc;
    } lookup_rsp_t;

endpackage

// File: hdl/mmu_tlb_pkg.sv
package mmu_tlb_pkg;

    typedef logic [9:0] asid_t;

    typedef struct packed {
        logic        e;
        logic        g;
        asid_t       asid;
        logic [19:0] vppn;
        logic [19:0] ppn;
        logic        v;
        logic        d;
        logic [1:0]  plv;
    } tlb_entry_t;

    typedef struct packed {
        logic       plv0_en;
        logic       plv3_en;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    localparam logic [7:0] reg_ehi  = 8'h00;
    localparam logic [7:0] reg_elo  = 8'h04;
    localparam logic [7:0] reg_idx  = 8'h08;
    localparam logic [7:0] reg_asid = 8'h0C;
    localparam logic [7:0] reg_dmw0 = 8'h10;
    localparam logic [7:0] reg_dmw1 = 8'h14;

    // Register word holds PLV0 in bit 0, PLV3 in bit 3, PSEG in 27:25 and VSEG in 31:29
    function automatic dmw_t dmw_unpack(input logic [31:0] w);
        dmw_t d;
        d.plv0_en = w[0];
        d.plv3_en = w[3];
        d.pseg    = w[27:25];
        d.vseg    = w[31:29];
        return d;
    endfunction

    function automatic logic [31:0] dmw_pack(input dmw_t d);
        logic [31:0] w;
        w        = '0;
        w[0]     = d.plv0_en;
        w[3]     = d.plv3_en;
        w[27:25] = d.pseg;
        w[31:29] = d.vseg;
        return w;
    endfunction

endpackage

// File: hdl/tlb_array.sv
`timescale 1ns/10ps
module tlb_array #(
    parameter int tlb_entries = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             tlb_we,
    input  logic [$clog2(tlb_entries)-1:0]   tlb_idx,
    input  mmu_tlb_pkg::tlb_entry_t          tlb_wdata,
    input  mmu_tlb_pkg::asid_t               asid,
    input  mmu_exc_pkg::lookup_req_t         req0,
    input  mmu_exc_pkg::lookup_req_t         req1,
    output mmu_exc_pkg::tlb_hit_t            hit0,
    output mmu_exc_pkg::tlb_hit_t            hit1
);
    import mmu_exc_pkg::*;
    import mmu_tlb_pkg::*;

    tlb_entry_t             entries [tlb_entries];
    logic [tlb_entries-1:0] valid_q;

    function automatic logic entry_match(
        input tlb_entry_t  ent,
        input logic        ent_valid,
        input logic [19:0] vpn,
        input asid_t       cur_asid
    );
        return ent_valid && (ent.vppn == vpn) && (ent.g || (ent.asid == cur_asid));
    endfunction

    function automatic tlb_hit_t to_hit(input tlb_entry_t ent);
        tlb_hit_t h;
        h.found = 1'b1;
        h.v     = ent.v;
        h.d     = ent.d;
        h.plv   = ent.plv;
        h.ppn   = ent.ppn;
        return h;
    endfunction

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            entries[tlb_idx] <= tlb_wdata;
        end
    end

    // Valid bits are cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tlb_we) begin
            valid_q[tlb_idx] <= tlb_wdata.e;
        end
    end

    // Walk down so the lowest matching index is the one returned
    always_comb begin
        hit0 = '0;
        hit1 = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (entry_match(entries[i], valid_q[i], req0.vaddr[31:12], asid)) begin
                hit0 = to_hit(entries[i]);
            end
            if (entry_match(entries[i], valid_q[i], req1.vaddr[31:12], asid)) begin
                hit1 = to_hit(entries[i]);
            end
        end
    end

endmodule

// File: hdl/dmw_match.sv
`timescale 1ns/10ps
module dmw_match (
    input  mmu_tlb_pkg::dmw_t         dmw0,
    input  mmu_tlb_pkg::dmw_t         dmw1,
    input  mmu_exc_pkg::lookup_req_t  req0,
    input  mmu_exc_pkg::lookup_req_t  req1,
    output logic                      dmw_hit0,
    output logic                      dmw_hit1,
    output logic [31:0]               dmw_pa0,
    output logic [31:0]               dmw_pa1
);
    import mmu_exc_pkg::*;
    import mmu_tlb_pkg::*;

    function automatic logic win_hit(input dmw_t w, input lookup_req_t r);
        logic lvl_ok;
        lvl_ok = ((r.plv == 2'd0) && w.plv0_en) || ((r.plv == 2'd3) && w.plv3_en);
        return lvl_ok && (r.vaddr[31:29] == w.vseg);
    endfunction

    // Window 0 has priority when both match
    function automatic logic [31:0] win_pa(input lookup_req_t r);
        logic [2:0] seg;
        seg = win_hit(dmw0, r) ? dmw0.pseg : dmw1.pseg;
        return {seg, r.vaddr[28:0]};
    endfunction

    assign dmw_hit0 = win_hit(dmw0, req0) || win_hit(dmw1, req0);
    assign dmw_hit1 = win_hit(dmw0, req1) || win_hit(dmw1, req1);
    assign dmw_pa0  = win_pa(req0);
    assign dmw_pa1  = win_pa(req1);

endmodule

// File: hdl/tlb_exp_handler.sv
`timescale 1ns/10ps
module tlb_exp_handler (
    input  mmu_exc_pkg::lookup_req_t  req0,
    input  mmu_exc_pkg::lookup_req_t  req1,
    input  mmu_exc_pkg::tlb_hit_t     hit0,
    input  mmu_exc_pkg::tlb_hit_t     hit1,
    input  logic                      dmw_hit0,
    input  logic                      dmw_hit1,
    output mmu_exc_pkg::exc_code_t    exc0,
    output mmu_exc_pkg::exc_code_t    exc1
);
    import mmu_exc_pkg::*;

    // Only ade_code differs between the two ports
    function automatic exc_code_t check(
        input lookup_req_t r,
        input tlb_hit_t    h,
        input exc_code_t   ade_code
    );
        exc_code_t code;
        code = exc_none;
        if ((r.plv == 2'd3) && r.vaddr[31]) begin
            code = ade_code;
        end else if (!h.found) begin
            code = exc_tlbr;
        end else if (!h.v) begin
            case (r.mem_type)
                mem_fetch: code = exc_pif;
                mem_load:  code = exc_pil;
                mem_store: code = exc_pis;
                default:   code = exc_none;
            endcase
        end else if (r.plv > h.plv) begin
            code = exc_ppi;
        end else if ((r.mem_type == mem_store) && !h.d) begin
            code = exc_pme;
        end
        return code;
    endfunction

    // Direct mapped or idle ports never fault
    assign exc0 = (req0.en && !dmw_hit0) ? check(req0, hit0, exc_adef) : exc_none;
    assign exc1 = (req1.en && !dmw_hit1) ? check(req1, hit1, exc_adem) : exc_none;

endmodule

// File: hdl/mmu_wb_regs.sv
`timescale 1ns/10ps
module mmu_wb_regs #(
    parameter int tlb_entries = 16
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [7:0]                       wb_adr,
    input  logic [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack,
    output logic                             tlb_we,
    output logic [$clog2(tlb_entries)-1:0]   tlb_idx,
    output mmu_tlb_pkg::tlb_entry_t          tlb_wdata,
    output mmu_tlb_pkg::asid_t               asid,
    output mmu_tlb_pkg::dmw_t                dmw0,
    output mmu_tlb_pkg::dmw_t                dmw1
);
    import mmu_tlb_pkg::*;

    localparam int idx_w = $clog2(tlb_entries);

    logic             ack_q;
    logic             fire;
    logic [19:0]      ehi_vppn_q;
    logic             ehi_g_q;
    logic [19:0]      elo_ppn_q;
    logic [1:0]       elo_plv_q;
    logic             elo_d_q;
    logic             elo_v_q;
    logic [idx_w-1:0] idx_q;
    logic             idx_e_q;
    asid_t            asid_q;
    dmw_t             dmw0_q;
    dmw_t             dmw1_q;
    logic [31:0]      rdata;

    // Writes commit on the edge that closes the ack cycle
    assign fire = ack_q & wb_cyc & wb_stb & wb_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            idx_q   <= '0;
            idx_e_q <= 1'b0;
            asid_q  <= '0;
            dmw0_q  <= '0;
            dmw1_q  <= '0;
        end else begin
            ack_q <= wb_cyc & wb_stb & ~ack_q;
            if (fire) begin
                case (wb_adr)
                    reg_idx: begin
                        idx_q   <= wb_dat_w[idx_w-1:0];
                        idx_e_q <= wb_dat_w[31];
                    end
                    reg_asid: asid_q <= wb_dat_w[9:0];
                    reg_dmw0: dmw0_q <= dmw_unpack(wb_dat_w);
                    reg_dmw1: dmw1_q <= dmw_unpack(wb_dat_w);
                    default: ;
                endcase
            end
        end
    end

    // Staging for the next entry write
    always_ff @(posedge clk) begin
        if (fire && (wb_adr == reg_ehi)) begin
            ehi_vppn_q <= wb_dat_w[31:12];
            ehi_g_q    <= wb_dat_w[0];
        end
        if (fire && (wb_adr == reg_elo)) begin
            elo_ppn_q <= wb_dat_w[31:12];
            elo_plv_q <= wb_dat_w[3:2];
            elo_d_q   <= wb_dat_w[1];
            elo_v_q   <= wb_dat_w[0];
        end
    end

    always_comb begin
        case (wb_adr)
            reg_ehi:  rdata = {ehi_vppn_q, 11'd0, ehi_g_q};
            reg_elo:  rdata = {elo_ppn_q, 8'd0, elo_plv_q, elo_d_q, elo_v_q};
            reg_idx:  rdata = {idx_e_q, {(31 - idx_w){1'b0}}, idx_q};
            reg_asid: rdata = {22'd0, asid_q};
            reg_dmw0: rdata = dmw_pack(dmw0_q);
            reg_dmw1: rdata = dmw_pack(dmw1_q);
            default:  rdata = '0;
        endcase
    end

    always_comb begin
        tlb_wdata      = '0;
        tlb_wdata.e    = wb_dat_w[31];
        tlb_wdata.g    = ehi_g_q;
        tlb_wdata.asid = asid_q;
        tlb_wdata.vppn = ehi_vppn_q;
        tlb_wdata.ppn  = elo_ppn_q;
        tlb_wdata.v    = elo_v_q;
        tlb_wdata.d    = elo_d_q;
        tlb_wdata.plv  = elo_plv_q;
    end

    assign tlb_we   = fire && (wb_adr == reg_idx);
    assign tlb_idx  = wb_dat_w[idx_w-1:0];
    assign wb_ack   = ack_q;
    assign wb_dat_r = ack_q ? rdata : 32'd0;
    assign asid     = asid_q;
    assign dmw0     = dmw0_q;
    assign dmw1     = dmw1_q;

endmodule

// File: hdl/mmu_top.sv
`timescale 1ns/10ps
module mmu_top #(
    parameter int tlb_entries = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [7:0]                wb_adr,
    input  logic [31:0]               wb_dat_w,
    output logic [31:0]               wb_dat_r,
    output logic                      wb_ack,
    input  mmu_exc_pkg::lookup_req_t  req0,
    input  mmu_exc_pkg::lookup_req_t  req1,
    output mmu_exc_pkg::lookup_rsp_t  rsp0,
    output mmu_exc_pkg::lookup_rsp_t  rsp1
);
    import mmu_exc_pkg::*;
    import mmu_tlb_pkg::*;

    logic                           tlb_we;
    logic [$clog2(tlb_entries)-1:0] tlb_idx;
    tlb_entry_t                     tlb_wdata;
    asid_t                          asid;
    dmw_t                           dmw0;
    dmw_t                           dmw1;
    tlb_hit_t                       hit0;
    tlb_hit_t                       hit1;
    logic                           dmw_hit0;
    logic                           dmw_hit1;
    logic [31:0]                    dmw_pa0;
    logic [31:0]                    dmw_pa1;
    exc_code_t                      exc0;
    exc_code_t                      exc1;

    mmu_wb_regs #(.tlb_entries(tlb_entries)) u_regs (.*);

    tlb_array #(.tlb_entries(tlb_entries)) u_tlb (.*);

    dmw_match u_dmw (.*);

    tlb_exp_handler u_exc (.*);

    // Page frame plus offset unless a window hits
    assign rsp0.paddr   = dmw_hit0 ? dmw_pa0 : {hit0.ppn, req0.vaddr[11:0]};
    assign rsp0.dmw_hit = dmw_hit0;
    assign rsp0.exc     = exc0;
    assign rsp1.paddr   = dmw_hit1 ? dmw_pa1 : {hit1.ppn, req1.vaddr[11:0]};
    assign rsp1.dmw_hit = dmw_hit1;
    assign rsp1.exc     = exc1;

endmodule

// File: tests/mmu_assertions.sv
`timescale 1ns/10ps
module mmu_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      wb_cyc,
    input logic                      wb_stb,
    input logic                      wb_ack,
    input mmu_exc_pkg::lookup_req_t  req0,
    input mmu_exc_pkg::lookup_req_t  req1,
    input mmu_exc_pkg::lookup_rsp_t  rsp0,
    input mmu_exc_pkg::lookup_rsp_t  rsp1
);
    import mmu_exc_pkg::*;

    // Failure count polled by the testbench
    int fail_cnt = 0;

    ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        $error("wb_ack raised without a strobe in the cycle before");
        fail_cnt++;
    end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
    else begin
        $error("wb_ack held high for two cycles");
        fail_cnt++;
    end

    ack_low_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_ack)
    else begin
        $error("wb_ack high during reset");
        fail_cnt++;
    end

    // Idle or direct mapped ports carry no exception
    exc0_masked: assert property (@(posedge clk) disable iff (!rst_n)
        (!req0.en || rsp0.dmw_hit) |-> (rsp0.exc == exc_none))
    else begin
        $error("port 0 exception not masked");
        fail_cnt++;
    end

    exc1_masked: assert property (@(posedge clk) disable iff (!rst_n)
        (!req1.en || rsp1.dmw_hit) |-> (rsp1.exc == exc_none))
    else begin
        $error("port 1 exception not masked");
        fail_cnt++;
    end

endmodule

bind mmu_top mmu_assertions u_chk (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .req0   (req0),
    .req1   (req1),
    .rsp0   (rsp0),
    .rsp1   (rsp1)
);

// File: tests/mmu_tb.sv
`timescale 1ns/10ps
module mmu_tb;
    import mmu_exc_pkg::*;
    import mmu_tlb_pkg::*;

    localparam int n_entries = 16;
    // Roughly four times the cycles the sequence below needs
    localparam int max_cycles = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    lookup_req_t req0;
    lookup_req_t req1;
    lookup_rsp_t rsp0;
    lookup_rsp_t rsp1;

    // Reference state
    tlb_entry_t  shadow [n_entries];
    logic [31:0] ehi_w;
    logic [31:0] elo_w;
    logic [31:0] dmw0_w;
    logic [31:0] dmw1_w;
    asid_t       asid_w;
    logic [19:0] vq [$];
    logic [31:0] lfsr = 32'h64d60573;
    int          cycle_cnt = 0;

    mmu_top #(.tlb_entries(n_entries)) dut0 (.*);

    always #20 clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            fail_stop("Timeout: the run did not finish within the cycle limit");
        end else if (dut0.u_chk.fail_cnt != 0) begin
            fail_stop("A bound assertion on the DUT failed");
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic wb_xfer(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           output logic [31:0] rd);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rd = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] rd;
        int          i;
        wb_xfer(1'b1, adr, dat, rd);
        i = int'(dat[3:0]);
        case (adr)
            reg_ehi:  ehi_w = dat;
            reg_elo:  elo_w = dat;
            reg_asid: asid_w = dat[9:0];
            reg_dmw0: dmw0_w = dat;
            reg_dmw1: dmw1_w = dat;
            reg_idx: begin
                shadow[i].e    = dat[31];
                shadow[i].g    = ehi_w[0];
                shadow[i].asid = asid_w;
                shadow[i].vppn = ehi_w[31:12];
                shadow[i].ppn  = elo_w[31:12];
                shadow[i].plv  = elo_w[3:2];
                shadow[i].d    = elo_w[1];
                shadow[i].v    = elo_w[0];
            end
            default: ;
        endcase
    endtask

    task automatic reg_read_check(input logic [7:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        wb_xfer(1'b0, adr, 32'd0, rd);
        check_val($sformatf("wb_dat_r@%h", adr), rd, exp);
    endtask

    function automatic lookup_req_t make_req(input logic en, input logic [31:0] va,
                                             input mem_type_t mt, input logic [1:0] plv);
        lookup_req_t r;
        r.en       = en;
        r.vaddr    = va;
        r.mem_type = mt;
        r.plv      = plv;
        return r;
    endfunction

    function automatic lookup_rsp_t expect_rsp(input lookup_req_t r, input exc_code_t ade);
        lookup_rsp_t x;
        tlb_entry_t  m;
        logic        found;
        logic [31:0] w;
        x     = '0;
        m     = '0;
        found = 1'b0;
        // Window 1 first so that window 0 overrides it
        for (int k = 1; k >= 0; k--) begin
            w = (k == 0) ? dmw0_w : dmw1_w;
            if ((r.vaddr[31:29] == w[31:29])
                    && (((r.plv == 2'd0) && w[0]) || ((r.plv == 2'd3) && w[3]))) begin
                x.dmw_hit = 1'b1;
                x.paddr   = {w[27:25], r.vaddr[28:0]};
            end
        end
        for (int k = n_entries - 1; k >= 0; k--) begin
            if (shadow[k].e && (shadow[k].vppn == r.vaddr[31:12])
                    && (shadow[k].g || (shadow[k].asid == asid_w))) begin
                m     = shadow[k];
                found = 1'b1;
            end
        end
        if (!x.dmw_hit) begin
            x.paddr = {m.ppn, r.vaddr[11:0]};
        end
        if (!r.en || x.dmw_hit) begin
            x.exc = exc_none;
        end else if ((r.plv == 2'd3) && r.vaddr[31]) begin
            x.exc = ade;
        end else if (!found) begin
            x.exc = exc_tlbr;
        end else if (!m.v) begin
            case (r.mem_type)
                mem_fetch: x.exc = exc_pif;
                mem_store: x.exc = exc_pis;
                default:   x.exc = exc_pil;
            endcase
        end else if (r.plv > m.plv) begin
            x.exc = exc_ppi;
        end else if ((r.mem_type == mem_store) && !m.d) begin
            x.exc = exc_pme;
        end
        return x;
    endfunction

    task automatic check_rsp(input string name, input lookup_req_t r,
                             input lookup_rsp_t got, input lookup_rsp_t exp);
        check_val({name, ".exc"}, 32'(got.exc), 32'(exp.exc));
        if (r.en) begin
            check_val({name, ".dmw_hit"}, 32'(got.dmw_hit), 32'(exp.dmw_hit));
        end
        // paddr is only defined for a clean translation
        if (r.en && (exp.exc == exc_none)) begin
            check_val({name, ".paddr"}, got.paddr, exp.paddr);
        end
    endtask

    task automatic lookup(input lookup_req_t r0, input lookup_req_t r1);
        @(posedge clk);
        req0 <= r0;
        req1 <= r1;
        @(negedge clk);
        check_rsp("rsp0", r0, rsp0, expect_rsp(r0, exc_adef));
        check_rsp("rsp1", r1, rsp1, expect_rsp(r1, exc_adem));
    endtask

    function automatic logic [31:0] pick_vaddr();
        logic [31:0] k;
        logic [31:0] off;
        logic [19:0] vpn;
        k   = rand_bits(8);
        off = rand_bits(12);
        // Mostly filled pages and now and then any page of the same small pool
        if ((k[7:6] != 2'b00) && (vq.size() > 0)) begin
            vpn = vq[k[5:0] % vq.size()];
        end else begin
            vpn = {k[5], 14'd0, k[4:0]};
        end
        return {vpn, off[11:0]};
    endfunction

    task automatic fill_random();
        logic [31:0] idx;
        logic [31:0] ppn;
        logic [31:0] bits;
        logic [19:0] vpn;
        idx  = rand_bits(4);
        ppn  = rand_bits(20);
        bits = rand_bits(12);
        vpn  = {bits[11], 14'd0, bits[10:6]};
        vq.push_back(vpn);
        reg_write(reg_ehi, {vpn, 11'd0, bits[5:4] == 2'b00});
        reg_write(reg_elo, {ppn[19:0], 8'd0, bits[3:2], bits[1], bits[0] | bits[5]});
        reg_write(reg_idx, {1'b1, 27'd0, idx[3:0]});
    endtask

    task automatic lookup_random();
        lookup_req_t r0;
        lookup_req_t r1;
        r0 = make_req(rand_bits(3) != 0, pick_vaddr(), mem_fetch, 2'(rand_bits(2)));
        r1 = make_req(rand_bits(3) != 0, pick_vaddr(),
                      rand_bits(1) ? mem_store : mem_load, 2'(rand_bits(2)));
        lookup(r0, r1);
    endtask

    initial begin
        logic [31:0] va;
        int          n;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        req0     = '0;
        req1     = '0;
        ehi_w    = '0;
        elo_w    = '0;
        dmw0_w   = '0;
        dmw1_w   = '0;
        asid_w   = '0;
        for (int i = 0; i < n_entries; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Empty TLB after reset
        lookup(make_req(1'b1, 32'h0040_1234, mem_fetch, 2'd0),
               make_req(1'b1, 32'h1234_5678, mem_load, 2'd0));
        lookup(make_req(1'b0, 32'h0040_1234, mem_fetch, 2'd0),
               make_req(1'b0, 32'h1234_5678, mem_store, 2'd0));

        // Register write and read back of the defined fields
        reg_write(reg_ehi, 32'h1234_5ABF);
        reg_read_check(reg_ehi, 32'h1234_5ABF & 32'hFFFF_F001);
        reg_write(reg_elo, 32'h9876_543D);
        reg_read_check(reg_elo, 32'h9876_543D & 32'hFFFF_F00F);
        reg_write(reg_asid, 32'hFFFF_F155);
        reg_read_check(reg_asid, 32'h0000_0155);
        reg_write(reg_dmw0, 32'hFFFF_FFFF);
        reg_read_check(reg_dmw0, 32'hEE00_0009);
        reg_write(reg_dmw1, 32'h5A5A_5A5A);
        reg_read_check(reg_dmw1, 32'h5A5A_5A5A & 32'hEE00_0009);
        reg_write(reg_dmw0, 32'd0);
        reg_write(reg_dmw1, 32'd0);
        reg_write(reg_idx, 32'h0000_0005);
        reg_read_check(reg_idx, 32'h0000_0005);
        reg_read_check(8'h18, 32'd0);

        // Random fills in batches with a new ASID per batch
        for (int b = 0; b < 4; b++) begin
            reg_write(reg_asid, rand_bits(10));
            for (int i = 0; i < 10; i++) begin
                fill_random();
            end
            for (int i = 0; i < 20; i++) begin
                lookup_random();
            end
        end

        // User level access to the upper half
        lookup(make_req(1'b1, 32'h8000_1000, mem_fetch, 2'd3),
               make_req(1'b1, 32'hC123_4000, mem_store, 2'd3));

        // Window 0 at PLV0 only and window 1 at PLV3 only
        reg_write(reg_dmw0, 32'hA200_0001);
        reg_write(reg_dmw1, 32'h8000_0008);
        lookup(make_req(1'b1, 32'hA000_1234, mem_fetch, 2'd0),
               make_req(1'b1, 32'hA7FF_FFF0, mem_store, 2'd0));
        lookup(make_req(1'b1, 32'hA000_1234, mem_fetch, 2'd3),
               make_req(1'b1, 32'h8000_0040, mem_load, 2'd3));
        lookup(make_req(1'b1, 32'hA000_1234, mem_fetch, 2'd1),
               make_req(1'b1, 32'h8000_0040, mem_load, 2'd0));
        for (int i = 0; i < 10; i++) begin
            lookup_random();
        end

        // Invalidate a few live entries under their own ASID
        n = 0;
        for (int i = 0; (i < n_entries) && (n < 4); i++) begin
            if (shadow[i].e) begin
                reg_write(reg_asid, {22'd0, shadow[i].asid});
                va = {shadow[i].vppn, 12'h0A8};
                lookup(make_req(1'b1, va, mem_fetch, 2'd0), make_req(1'b1, va, mem_load, 2'd0));
                reg_write(reg_idx, i);
                lookup(make_req(1'b1, va, mem_fetch, 2'd0), make_req(1'b1, va, mem_load, 2'd0));
                n++;
            end
        end

        repeat (2) @(posedge clk);
        if (dut0.u_chk.fail_cnt != 0) begin
            fail_stop("A bound assertion on the DUT failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: verilog.f
hdl/mmu_exc_pkg.sv
hdl/mmu_tlb_pkg.sv
hdl/tlb_array.sv
hdl/dmw_match.sv
hdl/tlb_exp_handler.sv
hdl/mmu_wb_regs.sv
hdl/mmu_top.sv
tests/mmu_assertions.sv
tests/mmu_tb.sv

// File: Bender.yml
package:
  name: mmu_tlb

sources:
  - hdl/mmu_exc_pkg.sv
  - hdl/mmu_tlb_pkg.sv
  - hdl/tlb_array.sv
  - hdl/dmw_match.sv
  - hdl/tlb_exp_handler.sv
  - hdl/mmu_wb_regs.sv
  - hdl/mmu_top.sv
  - target: test
    files:
      - tests/mmu_assertions.sv
      - tests/mmu_tb.sv
